// File: ldpc_dec_pkg.sv
`default_nettype none

package ldpc_dec_pkg;

  //----------------------------------------------------------------------
  // Widths
  //----------------------------------------------------------------------

  // One output word
  localparam int cDAT_W   = 8;
  // Output buffer banks and bank select
  localparam int cDAT_NUM = 2;
  localparam int cSEL_W   = $clog2(cDAT_NUM);

  // Error count and counted bits share one width
  localparam int cERR_W   = 16;
  localparam int cTAG_W   = 4;
  localparam int cNITER_W = 8;

  //----------------------------------------------------------------------
  // Code tables
  //----------------------------------------------------------------------

  // Words per column, by lifting index
  localparam int cZC_WORDS [4] = '{2, 3, 4, 6};
  localparam int cZC_MAX       = 6;
  // Systematic columns, by base graph
  localparam int cGR_COL [2]   = '{22, 10};
  localparam int cCOL_MAX      = 22;

  // Columns held in one bank, rounded up
  localparam int cCOL_IN_BLOCK = (cCOL_MAX + cDAT_NUM - 1) / cDAT_NUM;

  // In-bank address covers 11 columns of the widest lifting
  localparam int cADDR_W    = $clog2(cCOL_IN_BLOCK * cZC_MAX);
  localparam int cRAM_DEPTH = 2 ** cADDR_W;

  // Counter widths
  localparam int cZC_W  = $clog2(cZC_MAX);
  localparam int cCOL_W = $clog2(cCOL_MAX + 1);

  typedef logic [cDAT_W-1:0]  dat_t;
  typedef logic [cSEL_W-1:0]  sel_t;
  typedef logic [cADDR_W-1:0] addr_t;
  typedef logic [cERR_W-1:0]  err_t;
  typedef logic [cZC_W-1:0]   zc_t;
  typedef logic [cCOL_W-1:0]  col_t;

  // Code context of one frame
  typedef struct packed {
    logic       gr;
    logic [1:0] zc_idx;
  } code_ctx_t;

  // Frame metadata from the decoder
  typedef struct packed {
    logic [cTAG_W-1:0]   tag;
    logic                decfail;
    logic [cERR_W-1:0]   err;
    logic [cNITER_W-1:0] niter;
  } frame_meta_t;

endpackage

`default_nettype wire

// File: ldpc_dec_sink_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ldpc_dec_sink_if;

  // One cycle, idle with buffer full
  logic start;
  // Read state and consumer request
  logic step;
  // Counters sit on the final word
  logic last;
  // Column count of the frame in work
  ldpc_dec_pkg::col_t col_lo;

  //----------------------------------------------------------------------
  // Views
  //----------------------------------------------------------------------

  modport fsm (output start, output step, input last);

  modport cnt (input start, input step, output last, output col_lo);

  modport out (input start, input step, input last, input col_lo);

endinterface

`default_nettype wire

// File: ldpc_dec_out_ram.sv
`timescale 1ns/1ps
`default_nettype none

module ldpc_dec_out_ram (
  input  logic                iclk,
  // Decoder write side
  input  logic                wr_en,
  input  ldpc_dec_pkg::sel_t  wr_bank,
  input  ldpc_dec_pkg::addr_t wr_addr,
  input  ldpc_dec_pkg::dat_t  wr_dat,
  // Sink read side, same address in all banks
  input  ldpc_dec_pkg::addr_t raddr,
  output ldpc_dec_pkg::dat_t  rdat [ldpc_dec_pkg::cDAT_NUM]
);

  // Address stage, first cycle of read latency
  ldpc_dec_pkg::addr_t raddr_r;

  always_ff @(posedge iclk) begin
    raddr_r <= raddr;
  end

  //----------------------------------------------------------------------
  // Banks
  //----------------------------------------------------------------------

  for (genvar b = 0; b < ldpc_dec_pkg::cDAT_NUM; b++) begin : g_bank
    ldpc_dec_pkg::dat_t mem [ldpc_dec_pkg::cRAM_DEPTH];
    ldpc_dec_pkg::dat_t rdat_q;

    always_ff @(posedge iclk) begin
      // One word per cycle into the addressed bank
      if (wr_en && (wr_bank == ldpc_dec_pkg::sel_t'(b))) begin
        mem[wr_addr] <= wr_dat;
      end
      // Output register, second cycle of latency
      rdat_q <= mem[raddr_r];
    end

    assign rdat[b] = rdat_q;
  end

endmodule

`default_nettype wire

// File: ldpc_dec_sink_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module ldpc_dec_sink_fsm (
  input  logic                iclk,
  input  logic                ireset,
  // Registered dec_done flag
  input  logic                buf_full,
  input  logic                req,
  ldpc_dec_sink_if.fsm        ctl,
  output logic                full,
  output logic                frame_free
);

  typedef enum logic {
    st_idle,
    st_read
  } state_t;

  state_t state;
  logic   start_d;

  //----------------------------------------------------------------------
  // Strobes
  //----------------------------------------------------------------------

  assign ctl.start = (state == st_idle) & buf_full;
  assign ctl.step  = (state == st_read) & req;

  // Final word taken, buffer can be refilled
  assign frame_free = ctl.step & ctl.last;

  //----------------------------------------------------------------------
  // State
  //----------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle : state <= buf_full   ? st_read : st_idle;
        st_read : state <= frame_free ? st_idle : st_read;
        default : state <= st_idle;
      endcase
    end
  end

  // Full flag, start plus two cycles
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      start_d <= 1'b0;
      full    <= 1'b0;
    end else begin
      start_d <= ctl.start;
      if (start_d) begin
        full <= 1'b1;
      end else if (frame_free) begin
        full <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: ldpc_dec_sink_cnt.sv
`timescale 1ns/1ps
`default_nettype none

module ldpc_dec_sink_cnt (
  input  logic                    iclk,
  input  logic                    ireset,
  input  ldpc_dec_pkg::code_ctx_t ctx,
  ldpc_dec_sink_if.cnt            ctl,
  output ldpc_dec_pkg::addr_t     raddr,
  output ldpc_dec_pkg::sel_t      rsel
);

  // Word in column and its last value
  ldpc_dec_pkg::zc_t  zc_cnt;
  ldpc_dec_pkg::zc_t  zc_m1;
  // Column in frame and its last value
  ldpc_dec_pkg::col_t col_cnt;
  ldpc_dec_pkg::col_t col_m1;
  // Column inside the current bank
  ldpc_dec_pkg::col_t bcol_cnt;

  logic zc_done;
  logic col_done;
  logic bcol_done;
  logic bank_wrap;

  //----------------------------------------------------------------------
  // Wrap points
  //----------------------------------------------------------------------

  assign zc_done   = (zc_cnt == zc_m1);
  assign col_done  = (col_cnt == col_m1);
  assign bcol_done = (bcol_cnt == ldpc_dec_pkg::col_t'(ldpc_dec_pkg::cCOL_IN_BLOCK - 1));
  // Last word of the last column in a bank
  assign bank_wrap = zc_done & bcol_done;

  assign ctl.last   = zc_done & col_done;
  // Columns of this graph, for bit counting
  assign ctl.col_lo = ldpc_dec_pkg::col_t'(ldpc_dec_pkg::cGR_COL[ctx.gr]);

  //----------------------------------------------------------------------
  // Counters and read address
  //----------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      zc_cnt   <= '0;
      zc_m1    <= '0;
      col_cnt  <= '0;
      col_m1   <= '0;
      bcol_cnt <= '0;
      raddr    <= '0;
      rsel     <= '0;
    end else if (ctl.start) begin
      // Frame sizes from the context
      zc_m1    <= ldpc_dec_pkg::zc_t'(ldpc_dec_pkg::cZC_WORDS[ctx.zc_idx] - 1);
      col_m1   <= ldpc_dec_pkg::col_t'(ldpc_dec_pkg::cGR_COL[ctx.gr] - 1);
      zc_cnt   <= '0;
      col_cnt  <= '0;
      bcol_cnt <= '0;
      raddr    <= '0;
      rsel     <= '0;
    end else if (ctl.step) begin
      zc_cnt <= zc_done ? '0 : zc_cnt + 1'b1;
      if (zc_done) begin
        col_cnt  <= col_cnt + 1'b1;
        bcol_cnt <= bcol_done ? '0 : bcol_cnt + 1'b1;
      end
      // Address runs through a bank, then the next bank
      raddr <= bank_wrap ? '0 : raddr + 1'b1;
      rsel  <= rsel + ldpc_dec_pkg::sel_t'(bank_wrap);
    end
  end

endmodule

`default_nettype wire

// File: ldpc_dec_sink_out.sv
`timescale 1ns/1ps
`default_nettype none

module ldpc_dec_sink_out (
  input  logic                      iclk,
  input  logic                      ireset,
  ldpc_dec_sink_if.out              ctl,
  input  ldpc_dec_pkg::code_ctx_t   ctx,
  input  ldpc_dec_pkg::frame_meta_t meta,
  input  ldpc_dec_pkg::sel_t        rsel,
  input  ldpc_dec_pkg::dat_t        rdat [ldpc_dec_pkg::cDAT_NUM],
  output logic                      sop,
  output logic                      eop,
  output logic                      val,
  output ldpc_dec_pkg::dat_t        dat,
  output logic [ldpc_dec_pkg::cTAG_W-1:0]   tag,
  output logic                              decfail,
  output ldpc_dec_pkg::err_t                err,
  output logic [ldpc_dec_pkg::cNITER_W-1:0] niter,
  output ldpc_dec_pkg::err_t                bitnum
);

  // Step to val, address, RAM and mux stages
  logic [2:0] val_sr;
  logic [2:0] eop_sr;
  logic       start_d;
  logic       sop_pend;

  ldpc_dec_pkg::sel_t        rsel_d [2];
  ldpc_dec_pkg::frame_meta_t meta_r;

  //----------------------------------------------------------------------
  // Strobes
  //----------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_sr   <= '0;
      eop_sr   <= '0;
      start_d  <= 1'b0;
      sop_pend <= 1'b0;
    end else begin
      val_sr  <= {val_sr[1:0], ctl.step};
      eop_sr  <= {eop_sr[1:0], ctl.step & ctl.last};
      start_d <= ctl.start;
      // Armed two cycles after start, dropped after first word
      if (start_d) begin
        sop_pend <= 1'b1;
      end else if (val_sr[2]) begin
        sop_pend <= 1'b0;
      end
    end
  end

  assign val = val_sr[2];
  assign eop = eop_sr[2];
  assign sop = sop_pend & val_sr[2];

  //----------------------------------------------------------------------
  // Data and metadata
  //----------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    // Bank select follows the two RAM stages
    rsel_d[0] <= rsel;
    rsel_d[1] <= rsel_d[0];
    dat       <= rdat[rsel_d[1]];
    if (ctl.start) begin
      meta_r <= meta;
      // Columns x words x bits per word
      bitnum <= ldpc_dec_pkg::err_t'(int'(ctl.col_lo) * ldpc_dec_pkg::cZC_WORDS[ctx.zc_idx]
                                     * ldpc_dec_pkg::cDAT_W);
    end
  end

  assign tag     = meta_r.tag;
  assign decfail = meta_r.decfail;
  assign err     = meta_r.err;
  assign niter   = meta_r.niter;

endmodule

`default_nettype wire

// File: ldpc_dec_out_top.sv
`timescale 1ns/1ps
`default_nettype none

module ldpc_dec_out_top (
  input  logic                iclk,
  input  logic                ireset,
  // Decoder writes, one word each
  input  logic                wr_en,
  input  ldpc_dec_pkg::sel_t  wr_bank,
  input  ldpc_dec_pkg::addr_t wr_addr,
  input  ldpc_dec_pkg::dat_t  wr_dat,
  // Frame done with context and metadata, one cycle
  input  logic                dec_done,
  input  logic                dec_gr,
  input  logic [1:0]          dec_zc_idx,
  input  logic [ldpc_dec_pkg::cTAG_W-1:0]   dec_tag,
  input  logic                              dec_decfail,
  input  ldpc_dec_pkg::err_t                dec_err,
  input  logic [ldpc_dec_pkg::cNITER_W-1:0] dec_niter,
  // Consumer side
  input  logic                              req,
  output logic                              full,
  output logic                              frame_free,
  output logic                              sop,
  output logic                              eop,
  output logic                              val,
  output ldpc_dec_pkg::dat_t                dat,
  output logic [ldpc_dec_pkg::cTAG_W-1:0]   tag,
  output logic                              decfail,
  output ldpc_dec_pkg::err_t                err,
  output ldpc_dec_pkg::err_t                bitnum,
  output logic [ldpc_dec_pkg::cNITER_W-1:0] niter
);

  logic                      buf_full;
  ldpc_dec_pkg::code_ctx_t   ctx_r;
  ldpc_dec_pkg::frame_meta_t meta_r;
  ldpc_dec_pkg::addr_t       raddr;
  ldpc_dec_pkg::sel_t        rsel;
  ldpc_dec_pkg::dat_t        rdat [ldpc_dec_pkg::cDAT_NUM];

  ldpc_dec_sink_if ctl ();

  //----------------------------------------------------------------------
  // Frame handoff from decoder
  //----------------------------------------------------------------------

  // Set by the decoder, freed by the sink
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      buf_full <= 1'b0;
    end else if (dec_done) begin
      buf_full <= 1'b1;
    end else if (frame_free) begin
      buf_full <= 1'b0;
    end
  end

  always_ff @(posedge iclk) begin
    if (dec_done) begin
      ctx_r.gr       <= dec_gr;
      ctx_r.zc_idx   <= dec_zc_idx;
      meta_r.tag     <= dec_tag;
      meta_r.decfail <= dec_decfail;
      meta_r.err     <= dec_err;
      meta_r.niter   <= dec_niter;
    end
  end

  //----------------------------------------------------------------------
  // Buffer and sink
  //----------------------------------------------------------------------

  ldpc_dec_out_ram out_ram (
    .iclk    (iclk),
    .wr_en   (wr_en),
    .wr_bank (wr_bank),
    .wr_addr (wr_addr),
    .wr_dat  (wr_dat),
    .raddr   (raddr),
    .rdat    (rdat)
  );

  ldpc_dec_sink_fsm sink_fsm (
    .iclk       (iclk),
    .ireset     (ireset),
    .buf_full   (buf_full),
    .req        (req),
    .ctl        (ctl.fsm),
    .full       (full),
    .frame_free (frame_free)
  );

  ldpc_dec_sink_cnt sink_cnt (
    .iclk   (iclk),
    .ireset (ireset),
    .ctx    (ctx_r),
    .ctl    (ctl.cnt),
    .raddr  (raddr),
    .rsel   (rsel)
  );

  ldpc_dec_sink_out sink_out (
    .iclk    (iclk),
    .ireset  (ireset),
    .ctl     (ctl.out),
    .ctx     (ctx_r),
    .meta    (meta_r),
    .rsel    (rsel),
    .rdat    (rdat),
    .sop     (sop),
    .eop     (eop),
    .val     (val),
    .dat     (dat),
    .tag     (tag),
    .decfail (decfail),
    .err     (err),
    .niter   (niter),
    .bitnum  (bitnum)
  );

endmodule

`default_nettype wire

// File: ldpc_dec_out_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module ldpc_dec_out_asserts (
  input logic iclk,
  input logic ireset,
  input logic start,
  input logic step,
  input logic full,
  input logic frame_free,
  input logic val,
  input logic sop,
  input logic eop
);

  //----------------------------------------------------------------------
  // Reset
  //----------------------------------------------------------------------

  // All flags quiet once reset lets go
  reset_quiet: assert property (@(posedge iclk)
    $fell(ireset) |-> !(full | frame_free | val | sop | eop))
    else begin
      tb_ldpc_dec_out.sva_errs++;
      $error("flags active at reset release");
    end

  //----------------------------------------------------------------------
  // Handshake timing
  //----------------------------------------------------------------------

  // Two-stage start delay
  full_after_start: assert property (@(posedge iclk) disable iff (ireset)
    start |-> ##2 $rose(full))
    else begin
      tb_ldpc_dec_out.sva_errs++;
      $error("full did not rise two cycles after start");
    end

  // Address, RAM and mux stages
  val_after_step: assert property (@(posedge iclk) disable iff (ireset)
    val == $past(step, 3))
    else begin
      tb_ldpc_dec_out.sva_errs++;
      $error("val not three cycles after step");
    end

  full_after_free: assert property (@(posedge iclk) disable iff (ireset)
    frame_free |=> $fell(full))
    else begin
      tb_ldpc_dec_out.sva_errs++;
      $error("full did not fall after frame_free");
    end

endmodule

`default_nettype wire

// File: tb_ldpc_dec_out.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ldpc_dec_out;

  localparam int          cCLK_PER = 8;
  localparam logic [31:0] cSEED    = 32'd90702;
  // Eight frames with req held high and four with random req
  localparam int          cNUM_FR  = 12;
  localparam int          cIDX_W   = ldpc_dec_pkg::cSEL_W + ldpc_dec_pkg::cADDR_W;

  logic                              iclk;
  logic                              ireset;
  logic                              wr_en;
  ldpc_dec_pkg::sel_t                wr_bank;
  ldpc_dec_pkg::addr_t               wr_addr;
  ldpc_dec_pkg::dat_t                wr_dat;
  logic                              dec_done;
  logic                              dec_gr;
  logic [1:0]                        dec_zc_idx;
  logic [ldpc_dec_pkg::cTAG_W-1:0]   dec_tag;
  logic                              dec_decfail;
  ldpc_dec_pkg::err_t                dec_err;
  logic [ldpc_dec_pkg::cNITER_W-1:0] dec_niter;
  logic                              req;
  logic                              full;
  logic                              frame_free;
  logic                              sop;
  logic                              eop;
  logic                              val;
  ldpc_dec_pkg::dat_t                dat;
  logic [ldpc_dec_pkg::cTAG_W-1:0]   tag;
  logic                              decfail;
  ldpc_dec_pkg::err_t                err;
  ldpc_dec_pkg::err_t                bitnum;
  logic [ldpc_dec_pkg::cNITER_W-1:0] niter;

  // Reference copy of both banks with the bank in the top index bit
  ldpc_dec_pkg::dat_t        ref_mem [2 ** cIDX_W];
  ldpc_dec_pkg::frame_meta_t exp_meta;
  logic [31:0]               rng;
  int exp_nz     = 1;
  int exp_total  = 0;
  int exp_bitnum = 0;
  // Running counts kept by the monitor
  int rx_cnt     = 0;
  int req_cnt    = 0;
  int rx_base    = 0;
  int req_base   = 0;
  int err_cnt    = 0;
  int sva_errs   = 0;
  // Read state window seen from the consumer side
  logic rd_on    = 1'b0;
  logic done_d   = 1'b0;

  ldpc_dec_out_top UUT (.*);

  bind ldpc_dec_out_top ldpc_dec_out_asserts asserts (
    .iclk       (iclk),
    .ireset     (ireset),
    .start      (ctl.start),
    .step       (ctl.step),
    .full       (full),
    .frame_free (frame_free),
    .val        (val),
    .sop        (sop),
    .eop        (eop)
  );

  initial begin
    iclk = 1'b0;
    forever #(cCLK_PER / 2) iclk = ~iclk;
  end

  //----------------------------------------------------------------------
  // Helpers
  //----------------------------------------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Frame list
  function automatic logic frame_gr(input int i);
    return 1'((i < 8) ? i / 4 : i % 2);
  endfunction

  function automatic logic [1:0] frame_zc(input int i);
    return 2'((i < 8) ? i % 4 : 11 - i);
  endfunction

  function automatic logic frame_rand_req(input int i);
    return i >= 8;
  endfunction

  function automatic int total_words();
    int sum;
    sum = 0;
    for (int i = 0; i < cNUM_FR; i++) begin
      sum += ldpc_dec_pkg::cGR_COL[frame_gr(i)] * ldpc_dec_pkg::cZC_WORDS[frame_zc(i)];
    end
    return sum;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (exp == got) else begin
      err_cnt++;
      $display("ERR %0t %s exp %0h got %0h", $time, name, exp, got);
    end
  endtask

  //----------------------------------------------------------------------
  // Scoreboard
  //----------------------------------------------------------------------

  // Word n of the frame is word n % nz of column n / nz
  task automatic check_word();
    int n;
    int c;
    logic [cIDX_W-1:0] idx;
    n = rx_cnt - rx_base;
    if (n >= exp_total) begin
      err_cnt++;
      $display("Output word at %0t came after the frame was complete", $time);
    end else begin
      c   = n / exp_nz;
      idx = cIDX_W'((c / ldpc_dec_pkg::cCOL_IN_BLOCK) * ldpc_dec_pkg::cRAM_DEPTH
                    + (c % ldpc_dec_pkg::cCOL_IN_BLOCK) * exp_nz + n % exp_nz);
      check_eq("dat", 32'(ref_mem[idx]), 32'(dat));
      check_eq("sop", 32'(n == 0), 32'(sop));
      check_eq("eop", 32'(n == exp_total - 1), 32'(eop));
      check_eq("tag", 32'(exp_meta.tag), 32'(tag));
      check_eq("decfail", 32'(exp_meta.decfail), 32'(decfail));
      check_eq("err", 32'(exp_meta.err), 32'(err));
      check_eq("niter", 32'(exp_meta.niter), 32'(niter));
      check_eq("bitnum", exp_bitnum, 32'(bitnum));
      // At frame end every request in the read state produced one word
      if (eop) begin
        check_eq("val_count", exp_total, n + 1);
        check_eq("req_cycles", req_cnt - req_base, n + 1);
      end
    end
    rx_cnt++;
  endtask

  // Read state runs from two cycles after dec_done to the frame_free cycle
  always @(posedge iclk) begin
    if (!ireset) begin
      if (rd_on && req) begin
        req_cnt++;
      end
      if (frame_free) begin
        rd_on = 1'b0;
      end
      if (done_d) begin
        rd_on = 1'b1;
      end
      done_d = dec_done;
      if (val) begin
        check_word();
      end
    end
  end

  //----------------------------------------------------------------------
  // Stimulus
  //----------------------------------------------------------------------

  task automatic run_frame(input int fr);
    int                ncol;
    int                nz;
    logic [cIDX_W-1:0] idx;
    ncol = ldpc_dec_pkg::cGR_COL[frame_gr(fr)];
    nz   = ldpc_dec_pkg::cZC_WORDS[frame_zc(fr)];
    // Fill the buffer column by column with one word per cycle
    for (int c = 0; c < ncol; c++) begin
      for (int z = 0; z < nz; z++) begin
        rng          = xorshift(rng);
        idx          = cIDX_W'((c / ldpc_dec_pkg::cCOL_IN_BLOCK) * ldpc_dec_pkg::cRAM_DEPTH
                               + (c % ldpc_dec_pkg::cCOL_IN_BLOCK) * nz + z);
        wr_en        = 1'b1;
        wr_bank      = idx[ldpc_dec_pkg::cADDR_W +: ldpc_dec_pkg::cSEL_W];
        wr_addr      = idx[ldpc_dec_pkg::cADDR_W-1:0];
        wr_dat       = rng[7:0];
        ref_mem[idx] = rng[7:0];
        @(negedge iclk);
      end
    end
    wr_en = 1'b0;
    rng   = xorshift(rng);
    exp_meta.tag     = rng[3:0];
    exp_meta.decfail = rng[4];
    exp_meta.err     = rng[20:5];
    exp_meta.niter   = rng[28:21];
    exp_nz     = nz;
    exp_total  = ncol * nz;
    exp_bitnum = ncol * nz * ldpc_dec_pkg::cDAT_W;
    rx_base    = rx_cnt;
    req_base   = req_cnt;
    // Frame done pulse for one cycle
    dec_done    = 1'b1;
    dec_gr      = frame_gr(fr);
    dec_zc_idx  = frame_zc(fr);
    dec_tag     = exp_meta.tag;
    dec_decfail = exp_meta.decfail;
    dec_err     = exp_meta.err;
    dec_niter   = exp_meta.niter;
    @(negedge iclk);
    dec_done = 1'b0;
    // Consumer runs until every word is in and the buffer is free
    while ((rx_cnt - rx_base) < exp_total || full) begin
      rng = xorshift(rng);
      req = frame_rand_req(fr) ? (rng[2:0] < 3'd5) : 1'b1;
      @(negedge iclk);
    end
    req = 1'b0;
    // Room for a stray word to show up
    repeat (4) @(negedge iclk);
  endtask

  initial begin
    rng         = cSEED;
    ireset      = 1'b1;
    wr_en       = 1'b0;
    wr_bank     = '0;
    wr_addr     = '0;
    wr_dat      = '0;
    dec_done    = 1'b0;
    dec_gr      = 1'b0;
    dec_zc_idx  = '0;
    dec_tag     = '0;
    dec_decfail = 1'b0;
    dec_err     = '0;
    dec_niter   = '0;
    req         = 1'b0;
    exp_meta    = '0;
    repeat (2) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;
    @(negedge iclk);
    for (int fr = 0; fr < cNUM_FR; fr++) begin
      run_frame(fr);
    end
    $display("Errors: checks %0d, assertions %0d", err_cnt, sva_errs);
    if (err_cnt == 0 && sva_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog allows about four cycles per word of all frames plus slack
  initial begin
    repeat (total_words() * 4 + 500) @(posedge iclk);
    $display("Watchdog expired before all frames were read out");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
ldpc_dec_pkg.sv
ldpc_dec_sink_if.sv
ldpc_dec_out_ram.sv
ldpc_dec_sink_fsm.sv
ldpc_dec_sink_cnt.sv
ldpc_dec_sink_out.sv
ldpc_dec_out_top.sv
ldpc_dec_out_asserts.sv
tb_ldpc_dec_out.sv

// File: run.sh
#!/bin/sh
# Build and run the LDPC output stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_ldpc_dec_out -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

# Pass only when the testbench reports success
echo "$out" | grep -qx "TEST OK"
